/* hdl/timer_regs_pkg.sv */
//------------------------------------------------
// Timer register map
// Word addresses, bit positions and write masks
//------------------------------------------------
package timer_regs_pkg;

  localparam int TIMER_ADDR_W = 8;   // Word address width
  localparam int DATA_W       = 16;  // Bus and counter width
  localparam int CTL_W        = 10;  // Stored control register bits

  // Word addresses
  //------------------------------------------------
  typedef enum logic [TIMER_ADDR_W-1:0] {
    IV        = 8'h97,  // Interrupt vector
    CTL       = 8'hB0,  // Timer control
    CCTL_BASE = 8'hB1,  // Channel 0 control, channel n at +n
    TAR       = 8'hB8,  // Counter
    CCR_BASE  = 8'hB9   // Channel 0 compare, channel n at +n
  } reg_addr_e;

  // Control register fields
  //------------------------------------------------
  localparam int TAIFG_BIT    = 0;   // Overflow flag
  localparam int TAIE_BIT     = 1;   // Overflow interrupt enable
  localparam int TACLR_BIT    = 2;   // Clear strobe, not stored
  localparam int CTL_MC_LSB   = 4;   // Count mode, 2 bits
  localparam int CTL_ID_LSB   = 6;   // Input divider, 2 bits
  localparam int CTL_SSEL_LSB = 8;   // Clock source, 2 bits

  // Channel control register fields
  //------------------------------------------------
  localparam int CCIFG_BIT       = 0;  // Compare flag
  localparam int OUT_BIT         = 2;  // Output value for OM_OUTPUT
  localparam int CCIE_BIT        = 4;  // Compare interrupt enable
  localparam int CCTL_OUTMOD_LSB = 5;  // Output mode, 3 bits

  // Write masks
  //------------------------------------------------
  // Clear bit and reserved bits drop out
  localparam logic [CTL_W-1:0]  CTL_WR_MASK  = 10'h3F3;
  // Capture bits are gone, only compare bits stick
  localparam logic [DATA_W-1:0] CCTL_WR_MASK = 16'h00F5;

endpackage

/* hdl/timer_ctrl_pkg.sv */
//------------------------------------------------
// Timer control encodings
// Count mode, clock source, divider, output mode, IV
//------------------------------------------------
package timer_ctrl_pkg;

  // Count mode
  typedef enum logic [1:0] {
    MC_STOP   = 2'd0,  // Halted
    MC_UP     = 2'd1,  // 0 up to CCR0
    MC_CONT   = 2'd2,  // 0 up to FFFF
    MC_UPDOWN = 2'd3   // 0 up to CCR0 and back
  } mode_e;

  // Clock source select
  typedef enum logic [1:0] {
    SRC_TACLK = 2'd0,  // External, slow
    SRC_ACLK  = 2'd1,  // Enable from clock module
    SRC_SMCLK = 2'd2,  // Enable from clock module
    SRC_INCLK = 2'd3   // External, slow
  } clk_src_e;

  // Input divider
  typedef enum logic [1:0] {
    DIV_1 = 2'd0,
    DIV_2 = 2'd1,
    DIV_4 = 2'd2,
    DIV_8 = 2'd3
  } clk_div_e;

  //------------------------------------------------
  // Output modes, second event is the CCR0 match
  typedef enum logic [2:0] {
    OM_OUTPUT       = 3'd0,  // Follows OUT bit
    OM_SET          = 3'd1,
    OM_TOGGLE_RESET = 3'd2,
    OM_SET_RESET    = 3'd3,
    OM_TOGGLE       = 3'd4,
    OM_RESET        = 3'd5,
    OM_TOGGLE_SET   = 3'd6,
    OM_RESET_SET    = 3'd7
  } out_mode_e;

  // Interrupt vector codes, lower code wins
  typedef enum logic [3:0] {
    IV_NONE = 4'd0,
    IV_CC1  = 4'd2,
    IV_CC2  = 4'd4,
    IV_CC3  = 4'd6,   // Only with NUM_CC above 3
    IV_CC4  = 4'd8,   // Only with NUM_CC of 5
    IV_OVF  = 4'd10
  } iv_code_e;

endpackage

/* hdl/timer_reg_bank.sv */
//------------------------------------------------
// Timer register bank
// Decode, control and compare regs, flags, IV, readback
//------------------------------------------------
`timescale 1ns/1ps

module timer_reg_bank import timer_regs_pkg::*, timer_ctrl_pkg::*; #(
  parameter int NUM_CC = 3                         // Compare channels, 2 to 5
) (
  input  logic                    mclk,
  input  logic                    puc,
  input  logic [TIMER_ADDR_W-1:0] per_addr,
  input  logic [DATA_W-1:0]       per_din,
  input  logic                    per_en,
  input  logic [1:0]              per_wen,
  input  logic                    irq_ta0_acc,     // Channel 0 interrupt taken
  input  logic [DATA_W-1:0]       tar,
  input  logic                    tar_clk,
  input  logic                    ovf_set,
  input  logic [NUM_CC-1:0]       equ,
  output logic [DATA_W-1:0]       per_dout,
  output mode_e                   mode,
  output clk_src_e                clk_src,
  output clk_div_e                clk_div,
  output logic                    taclr,
  output logic                    tar_wr,
  output logic [DATA_W-1:0]       ccr [NUM_CC],
  output out_mode_e               out_mode [NUM_CC],
  output logic [NUM_CC-1:0]       out_bit,
  output logic                    irq_ta0,
  output logic                    irq_ta1
);

  logic              reg_write;
  logic              reg_read;
  logic              ctl_sel, tar_sel, iv_sel;
  logic [NUM_CC-1:0] cctl_sel, ccr_sel;
  logic              ctl_wr, iv_acc;
  logic [CTL_W-1:0]  ctl;
  logic [DATA_W-1:0] cctl [NUM_CC];
  logic [NUM_CC-1:0] ccifg_set, ccifg_clr, cc_pend;
  logic              taifg_clr;
  iv_code_e          iv;

  //------------------------------------------------
  // Address decode
  //------------------------------------------------
  assign reg_write = per_en & (|per_wen);
  assign reg_read  = per_en & ~(|per_wen);

  assign ctl_sel = (per_addr == CTL);
  assign tar_sel = (per_addr == TAR);
  assign iv_sel  = (per_addr == IV);

  assign ctl_wr  = reg_write & ctl_sel;
  assign tar_wr  = reg_write & tar_sel;
  assign taclr   = ctl_wr & per_din[TACLR_BIT];  // Strobe only
  assign iv_acc  = per_en & iv_sel;              // Read or write

  // Control register
  always_ff @(posedge mclk or posedge puc)
  begin
    if (puc)
      ctl <= '0;
    else
    begin
      if (ctl_wr)
        ctl <= per_din[CTL_W-1:0] & CTL_WR_MASK;
      if (ovf_set)
        ctl[TAIFG_BIT] <= 1'b1;                  // Event beats the write
      if (taifg_clr)
        ctl[TAIFG_BIT] <= 1'b0;                  // IV clear beats both
    end
  end

  assign mode    = mode_e'(ctl[CTL_MC_LSB +: 2]);
  assign clk_div = clk_div_e'(ctl[CTL_ID_LSB +: 2]);
  assign clk_src = clk_src_e'(ctl[CTL_SSEL_LSB +: 2]);

  //------------------------------------------------
  // Compare channels
  //------------------------------------------------
  for (genvar n = 0; n < NUM_CC; n++)
  begin : g_ch
    assign cctl_sel[n]  = (per_addr == TIMER_ADDR_W'(CCTL_BASE + n));
    assign ccr_sel[n]   = (per_addr == TIMER_ADDR_W'(CCR_BASE + n));
    assign ccifg_set[n] = tar_clk & equ[n];
    assign cc_pend[n]   = cctl[n][CCIFG_BIT] & cctl[n][CCIE_BIT];

    always_ff @(posedge mclk or posedge puc)
    begin
      if (puc)
      begin
        cctl[n] <= '0;
        ccr[n]  <= '0;
      end
      else
      begin
        if (reg_write & cctl_sel[n])
          cctl[n] <= per_din & CCTL_WR_MASK;
        if (ccifg_set[n])
          cctl[n][CCIFG_BIT] <= 1'b1;
        if (ccifg_clr[n])
          cctl[n][CCIFG_BIT] <= 1'b0;
        if (reg_write & ccr_sel[n])
          ccr[n] <= per_din;
      end
    end

    assign out_mode[n] = out_mode_e'(cctl[n][CCTL_OUTMOD_LSB +: 3]);
    assign out_bit[n]  = cctl[n][OUT_BIT];
  end

  //------------------------------------------------
  // Interrupt vector, channel 1 highest
  //------------------------------------------------
  always_comb
  begin
    iv = (ctl[TAIFG_BIT] & ctl[TAIE_BIT]) ? IV_OVF : IV_NONE;
    for (int n = NUM_CC - 1; n >= 1; n--)
      if (cc_pend[n])
        iv = iv_code_e'(4'(2 * n));              // Lower channel overrides
  end

  always_comb
  begin
    ccifg_clr[0] = irq_ta0_acc;                  // Channel 0 has its own vector
    for (int n = 1; n < NUM_CC; n++)
      ccifg_clr[n] = iv_acc & (iv == iv_code_e'(4'(2 * n)));
  end

  assign taifg_clr = iv_acc & (iv == IV_OVF);

  assign irq_ta0 = cc_pend[0];
  assign irq_ta1 = (|cc_pend[NUM_CC-1:1]) | (ctl[TAIFG_BIT] & ctl[TAIE_BIT]);

  // Readback mux, zero outside a read
  always_comb
  begin
    per_dout = '0;
    if (reg_read)
    begin
      if (ctl_sel) per_dout = {{(DATA_W - CTL_W){1'b0}}, ctl};
      if (tar_sel) per_dout = tar;
      if (iv_sel)  per_dout = {{(DATA_W - 4){1'b0}}, iv};
      for (int n = 0; n < NUM_CC; n++)
      begin
        if (cctl_sel[n]) per_dout = cctl[n];     // Capture bits read as zero
        if (ccr_sel[n])  per_dout = ccr[n];
      end
    end
  end

endmodule

/* hdl/timer_clock_gen.sv */
//------------------------------------------------
// Timer clock generator
// Source select and input divider, makes tar_clk
//------------------------------------------------
`timescale 1ns/1ps

module timer_clock_gen import timer_ctrl_pkg::*; (
  input  logic     mclk,
  input  logic     puc,
  input  logic     taclk,      // Slow external clock
  input  logic     inclk,      // Slow external clock
  input  logic     aclk_en,
  input  logic     smclk_en,
  input  clk_src_e clk_src,
  input  clk_div_e clk_div,
  input  mode_e    mode,
  input  logic     taclr,
  output logic     tar_clk     // One mclk per counter step
);

  logic [2:0] taclk_s, inclk_s;
  logic       taclk_en, inclk_en;
  logic       sel_pulse;
  logic       run;
  logic       div_hit;
  logic [2:0] div_cnt;

  //------------------------------------------------
  // Synchronizers with rising edge detect
  always_ff @(posedge mclk or posedge puc)
  begin
    if (puc)
    begin
      taclk_s <= '0;
      inclk_s <= '0;
    end
    else
    begin
      taclk_s <= {taclk_s[1:0], taclk};
      inclk_s <= {inclk_s[1:0], inclk};
    end
  end

  assign taclk_en = taclk_s[1] & ~taclk_s[2];
  assign inclk_en = inclk_s[1] & ~inclk_s[2];

  // Source mux
  always_comb
  begin
    unique case (clk_src)
      SRC_TACLK: sel_pulse = taclk_en;
      SRC_ACLK:  sel_pulse = aclk_en;
      SRC_SMCLK: sel_pulse = smclk_en;
      default:   sel_pulse = inclk_en;
    endcase
  end

  //------------------------------------------------
  // Divider, counts source pulses while running
  always_comb
  begin
    unique case (clk_div)
      DIV_1:   div_hit = 1'b1;
      DIV_2:   div_hit = div_cnt[0];
      DIV_4:   div_hit = &div_cnt[1:0];
      default: div_hit = &div_cnt;
    endcase
  end

  assign run     = (mode != MC_STOP);
  assign tar_clk = run & sel_pulse & div_hit;

  always_ff @(posedge mclk or posedge puc)
  begin
    if (puc)
      div_cnt <= '0;
    else if (tar_clk | taclr)
      div_cnt <= '0;                 // Restart on each output pulse
    else if (run & sel_pulse)
      div_cnt <= div_cnt + 3'd1;
  end

endmodule

/* hdl/timer_counter.sv */
//------------------------------------------------
// Timer counter
// TAR register, up/down direction, overflow detect
//------------------------------------------------
`timescale 1ns/1ps

module timer_counter import timer_regs_pkg::*, timer_ctrl_pkg::*; (
  input  logic              mclk,
  input  logic              puc,
  input  logic              tar_clk,
  input  logic              dbg_freeze,  // Debug halt of the counter
  input  mode_e             mode,
  input  logic [DATA_W-1:0] ccr0,        // Period in up and up/down modes
  input  logic              taclr,
  input  logic              tar_wr,
  input  logic [DATA_W-1:0] wr_data,
  output logic [DATA_W-1:0] tar,
  output logic [DATA_W-1:0] tar_nxt,
  output logic              ovf_set
);

  logic tar_dir;   // High while counting down
  logic tar_dec;
  logic at_top;

  assign at_top  = (tar >= ccr0);
  assign tar_dec = tar_dir | ((mode == MC_UPDOWN) & at_top);

  //------------------------------------------------
  // Next counter value per mode
  always_comb
  begin
    unique case (mode)
      MC_STOP:
        tar_nxt = tar;
      MC_UP:
        tar_nxt = at_top ? '0 : tar + 1'b1;
      MC_CONT:
        tar_nxt = tar + 1'b1;        // Natural wrap after FFFF
      default:
        if (ccr0 == '0)
          tar_nxt = '0;              // Zero period holds at 0
        else if (tar_dec)
          tar_nxt = tar - 1'b1;
        else
          tar_nxt = tar + 1'b1;
    endcase
  end

  // Up/down direction
  always_ff @(posedge mclk or posedge puc)
  begin
    if (puc)
      tar_dir <= 1'b0;
    else if (taclr)
      tar_dir <= 1'b0;
    else if (mode != MC_UPDOWN)
      tar_dir <= 1'b0;
    else if (tar_clk & (tar == 16'h0001))
      tar_dir <= 1'b0;               // Turn around at the bottom
    else if (at_top)
      tar_dir <= 1'b1;               // Turn around at CCR0
  end

  //------------------------------------------------
  // Counter register, write beats clear beats count
  always_ff @(posedge mclk or posedge puc)
  begin
    if (puc)
      tar <= '0;
    else if (tar_wr)
      tar <= wr_data;
    else if (taclr)
      tar <= '0;
    else if (tar_clk & ~dbg_freeze)
      tar <= tar_nxt;
  end

  // Wrap event for TAIFG
  always_comb
  begin
    unique case (mode)
      MC_UP:     ovf_set = (tar == ccr0);
      MC_CONT:   ovf_set = (tar == 16'hFFFF);
      MC_UPDOWN: ovf_set = (tar_nxt == '0) & tar_dec;
      default:   ovf_set = 1'b0;
    endcase
    ovf_set = ovf_set & tar_clk & ~dbg_freeze;
  end

endmodule

/* hdl/timer_compare_unit.sv */
//------------------------------------------------
// Compare channel
// Equal detect and output mode flip-flop
//------------------------------------------------
`timescale 1ns/1ps

module timer_compare_unit import timer_regs_pkg::*, timer_ctrl_pkg::*; (
  input  logic              mclk,
  input  logic              puc,
  input  logic [DATA_W-1:0] tar,
  input  logic [DATA_W-1:0] tar_nxt,
  input  logic [DATA_W-1:0] ccr,
  input  logic              tar_clk,
  input  logic              taclr,
  input  out_mode_e         out_mode,
  input  logic              out_bit,     // Level for OM_OUTPUT
  input  logic              period_equ,  // Channel 0 match
  output logic              equ,
  output logic              ta_out
);

  logic out_nxt;

  // Match on the step into ccr, once per pass
  assign equ = (tar_nxt == ccr) & (tar != ccr);

  //------------------------------------------------
  // Output mode decode, own match has priority
  always_comb
  begin
    out_nxt = ta_out;
    unique case (out_mode)
      OM_OUTPUT:       out_nxt = out_bit;
      OM_SET:          if (equ) out_nxt = 1'b1;
      OM_TOGGLE_RESET: out_nxt = equ ? ~ta_out : (period_equ ? 1'b0 : ta_out);
      OM_SET_RESET:    out_nxt = equ ? 1'b1    : (period_equ ? 1'b0 : ta_out);
      OM_TOGGLE:       if (equ) out_nxt = ~ta_out;
      OM_RESET:        if (equ) out_nxt = 1'b0;
      OM_TOGGLE_SET:   out_nxt = equ ? ~ta_out : (period_equ ? 1'b1 : ta_out);
      default:         out_nxt = equ ? 1'b0    : (period_equ ? 1'b1 : ta_out);
    endcase
  end

  always_ff @(posedge mclk or posedge puc)
  begin
    if (puc)
      ta_out <= 1'b0;
    else if ((out_mode == OM_SET) & taclr)
      ta_out <= 1'b0;                // Clear rearms set mode
    else if (tar_clk)
      ta_out <= out_nxt;
  end

endmodule

/* hdl/timer_a.sv */
//------------------------------------------------
// Timer A top level
// Register bank, clock gen, counter, compare units
//------------------------------------------------
`timescale 1ns/1ps

module timer_a import timer_regs_pkg::*, timer_ctrl_pkg::*; #(
  parameter int NUM_CC = 3                         // Compare channels, 2 to 5
) (
  input  logic                    mclk,
  input  logic                    puc,
  input  logic [TIMER_ADDR_W-1:0] per_addr,
  input  logic [DATA_W-1:0]       per_din,
  input  logic                    per_en,
  input  logic [1:0]              per_wen,
  output logic [DATA_W-1:0]       per_dout,
  input  logic                    aclk_en,
  input  logic                    smclk_en,
  input  logic                    taclk,
  input  logic                    inclk,
  input  logic                    dbg_freeze,
  input  logic                    irq_ta0_acc,
  output logic                    irq_ta0,         // CCR0 interrupt
  output logic                    irq_ta1,         // IV interrupt
  output logic [NUM_CC-1:0]       ta_out
);

  mode_e             mode;
  clk_src_e          clk_src;
  clk_div_e          clk_div;
  logic              taclr, tar_wr, tar_clk, ovf_set;
  logic [DATA_W-1:0] tar, tar_nxt;
  logic [DATA_W-1:0] ccr [NUM_CC];
  out_mode_e         out_mode [NUM_CC];
  logic [NUM_CC-1:0] out_bit, equ;

  timer_reg_bank #(.NUM_CC(NUM_CC)) u_reg_bank (
    .mclk, .puc, .per_addr, .per_din, .per_en, .per_wen, .irq_ta0_acc,
    .tar, .tar_clk, .ovf_set, .equ,
    .per_dout, .mode, .clk_src, .clk_div, .taclr, .tar_wr,
    .ccr, .out_mode, .out_bit, .irq_ta0, .irq_ta1
  );

  timer_clock_gen u_clock_gen (
    .mclk, .puc, .taclk, .inclk, .aclk_en, .smclk_en,
    .clk_src, .clk_div, .mode, .taclr, .tar_clk
  );

  timer_counter u_counter (
    .mclk, .puc, .tar_clk, .dbg_freeze, .mode,
    .ccr0    (ccr[0]),                             // Period register
    .taclr, .tar_wr,
    .wr_data (per_din),
    .tar, .tar_nxt, .ovf_set
  );

  //------------------------------------------------
  // One compare unit per channel
  for (genvar n = 0; n < NUM_CC; n++)
  begin : g_cc
    timer_compare_unit u_compare (
      .mclk, .puc, .tar, .tar_nxt,
      .ccr        (ccr[n]),
      .tar_clk, .taclr,
      .out_mode   (out_mode[n]),
      .out_bit    (out_bit[n]),
      .period_equ (equ[0]),                        // Reset/set second event
      .equ        (equ[n]),
      .ta_out     (ta_out[n])
    );
  end

endmodule

/* verification/timer_a_tb.sv */
//------------------------------------------------
// Timer A testbench
// Bus access, count modes, compare outputs, IRQs
//------------------------------------------------
`timescale 1ns/1ps

module timer_a_tb import timer_regs_pkg::*, timer_ctrl_pkg::*;;

  localparam int CLK_PERIOD  = 4;
  localparam int NUM_CC      = 3;
  // Summed cycle budgets of the tests
  localparam int TEST_CYCLES = 100 + 500 + 900 + 500 + 1300 + 200;

  logic              mclk, puc;
  logic [7:0]        per_addr;
  logic [15:0]       per_din, per_dout;
  logic              per_en;
  logic [1:0]        per_wen;
  logic              aclk_en, smclk_en, taclk, inclk, dbg_freeze, irq_ta0_acc;
  logic              irq_ta0, irq_ta1;
  logic [NUM_CC-1:0] ta_out;

  logic [31:0] lcg_state = 32'hab40064d;
  string       test_name = "startup";
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  timer_a #(.NUM_CC(NUM_CC)) u_dut (
    .mclk, .puc, .per_addr, .per_din, .per_en, .per_wen, .per_dout,
    .aclk_en, .smclk_en, .taclk, .inclk, .dbg_freeze, .irq_ta0_acc,
    .irq_ta0, .irq_ta1, .ta_out
  );

  initial
  begin
    mclk = 1'b0;
    forever #(CLK_PERIOD / 2) mclk = ~mclk;
  end

  // Watchdog at twice the summed test budgets
  initial
  begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("Watchdog: run did not finish within %0d ns", 2 * TEST_CYCLES * CLK_PERIOD);
    $display("SOME TESTS FAILED");
    $finish;
  end

  // Bus output must idle at zero
  always @(negedge mclk)
  begin
    if (!puc && !per_en)
      assert (per_dout == 16'h0)
      else
      begin
        $display("Error: %s idle per_dout expected 0 actual %0h", test_name, per_dout);
        test_errors++;
      end
  end

  //------------------------------------------------
  // Helpers
  //------------------------------------------------
  function automatic logic [15:0] rand16();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;  // Numerical Recipes LCG
    return lcg_state[31:16];                                // Upper half of the state
  endfunction

  function automatic int pick(input int lo, input int span);
    return lo + int'(rand16()) % span;
  endfunction

  function automatic logic [15:0] make_ctl(input mode_e m, input clk_src_e s, input clk_div_e d,
                                           input logic taie, input logic clr);
    logic [15:0] w;
    w = '0;
    w[CTL_MC_LSB +: 2]   = m;
    w[CTL_SSEL_LSB +: 2] = s;
    w[CTL_ID_LSB +: 2]   = d;
    w[TAIE_BIT]          = taie;
    w[TACLR_BIT]         = clr;
    return w;
  endfunction

  task automatic check_eq(input string what, input logic [15:0] exp, input logic [15:0] act);
    assert (act === exp)
    else
    begin
      $display("Error: %s %s expected %0h actual %0h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_max(input string what, input logic [15:0] hi, input logic [15:0] act);
    assert (act <= hi)
    else
    begin
      $display("Error: %s %s expected <= %0h actual %0h", test_name, what, hi, act);
      test_errors++;
    end
  endtask

  task automatic note_failure(input string msg);
    $display("%s: %s", test_name, msg);
    test_errors++;
  endtask

  task automatic apply_reset();
    puc         = 1'b1;
    per_en      = 1'b0;
    per_wen     = 2'b00;
    taclk       = 1'b0;
    dbg_freeze  = 1'b0;
    irq_ta0_acc = 1'b0;
    repeat (4) @(posedge mclk);
    #1;
    puc = 1'b0;
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
    apply_reset();
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0)
      $display("PASS %s", test_name);
    else
    begin
      tests_failed++;
      $display("FAIL %s with %0d errors", test_name, test_errors);
    end
  endtask

  // Bus cycles driven 1 ns after the edge
  task automatic bus_write(input logic [7:0] addr, input logic [15:0] data);
    @(posedge mclk);
    #1;
    per_addr = addr;
    per_din  = data;
    per_en   = 1'b1;
    per_wen  = 2'b11;
    @(posedge mclk);                 // Write lands here
    #1;
    per_en  = 1'b0;
    per_wen = 2'b00;
  endtask

  task automatic bus_read(input logic [7:0] addr, output logic [15:0] data);
    @(posedge mclk);
    #1;
    per_addr = addr;
    per_en   = 1'b1;
    per_wen  = 2'b00;
    #2 data = per_dout;              // Sampled late in the cycle
    @(posedge mclk);
    #1;
    per_en = 1'b0;
  endtask

  // Cycles until ta_out[1] changes or -1 on timeout
  task automatic measure_toggle(input int limit, output int cycles);
    logic prev;
    prev   = ta_out[1];
    cycles = -1;
    for (int i = 1; i <= limit; i++)
    begin
      @(posedge mclk);
      #1;
      if (ta_out[1] !== prev)
      begin
        cycles = i;
        break;
      end
    end
  endtask

  task automatic taclk_pulse();
    taclk = 1'b1;
    repeat (4) @(posedge mclk);      // Wider than the 3-stage sync
    #1;
    taclk = 1'b0;
    repeat (4) @(posedge mclk);
    #1;
  endtask

  //------------------------------------------------
  // Tests
  //------------------------------------------------
  task automatic test_register_access();
    logic [15:0] v, rd;
    begin_test("register_access");
    check_eq("irq_ta0 after reset", 0, irq_ta0);
    check_eq("irq_ta1 after reset", 0, irq_ta1);
    check_eq("ta_out after reset", 0, ta_out);
    check_eq("per_dout after reset", 0, per_dout);
    for (int n = 0; n < NUM_CC; n++)
    begin
      v = rand16();
      bus_write(8'(CCR_BASE + n), v);
      bus_read(8'(CCR_BASE + n), rd);
      check_eq($sformatf("CCR%0d readback", n), v, rd);
      v = rand16();
      bus_write(8'(CCTL_BASE + n), v);
      bus_read(8'(CCTL_BASE + n), rd);
      check_eq($sformatf("CCTL%0d readback", n), v & CCTL_WR_MASK, rd);
    end
    v = rand16() & ~(16'h3 << CTL_MC_LSB);  // Keep the counter stopped
    bus_write(CTL, v);
    bus_read(CTL, rd);
    check_eq("CTL readback", {6'b0, v[9:0] & CTL_WR_MASK}, rd);
    bus_read(8'h00, rd);
    check_eq("unmapped 00 read", 0, rd);
    bus_read(8'(CCR_BASE + NUM_CC), rd);     // No such channel
    check_eq("unmapped CCR read", 0, rd);
    end_test();
  endtask

  task automatic test_up_mode();
    int          n_per;
    logic        seen;
    logic [15:0] rd;
    begin_test("up_mode_overflow");
    n_per = pick(20, 40);
    bus_write(CCR_BASE, n_per);
    bus_write(CTL, make_ctl(MC_UP, SRC_SMCLK, DIV_1, 1'b1, 1'b1));
    seen = 1'b0;
    for (int i = 0; i < 200 && !seen; i++)
    begin
      bus_read(TAR, rd);
      check_max("TAR in up mode", n_per, rd);
      seen = irq_ta1;
    end
    if (!seen)
      note_failure("irq_ta1 never rose in up mode");
    else
    begin
      bus_read(IV, rd);              // Clears TAIFG on the same edge
      check_eq("IV overflow code", IV_OVF, rd);
      check_eq("irq_ta1 after IV read", 0, irq_ta1);
    end
    end_test();
  endtask

  task automatic test_priority();
    int          c1, c2, top;
    logic [15:0] rd;
    begin_test("cont_mode_priority");
    c1  = pick(16, 200);
    c2  = pick(16, 200);
    top = (c1 > c2) ? c1 : c2;
    bus_write(8'(CCR_BASE + 1), c1);
    bus_write(8'(CCR_BASE + 2), c2);
    bus_write(8'(CCTL_BASE + 1), 16'h1 << CCIE_BIT);
    bus_write(8'(CCTL_BASE + 2), 16'h1 << CCIE_BIT);
    bus_write(CTL, make_ctl(MC_CONT, SRC_SMCLK, DIV_1, 1'b0, 1'b1));
    rd = '0;
    for (int i = 0; i < 400 && rd <= top; i++)
      bus_read(TAR, rd);
    if (rd <= top)
      note_failure("counter never passed both compare values");
    else
    begin
      check_eq("irq_ta1 with both flags", 1, irq_ta1);
      bus_read(IV, rd);
      check_eq("first IV read", IV_CC1, rd);
      bus_read(IV, rd);
      check_eq("second IV read", IV_CC2, rd);
      bus_read(IV, rd);
      check_eq("third IV read", IV_NONE, rd);
    end
    end_test();
  endtask

  task automatic test_toggle_ack();
    int   n_per, cycles;
    logic seen;
    begin_test("toggle_output_ack");
    n_per = pick(10, 20);
    bus_write(CCR_BASE, n_per);
    bus_write(8'(CCR_BASE + 1), pick(0, n_per));       // Below the period
    bus_write(8'(CCTL_BASE + 1), 16'(OM_TOGGLE) << CCTL_OUTMOD_LSB);
    bus_write(CCTL_BASE, 16'h1 << CCIE_BIT);
    bus_write(CTL, make_ctl(MC_UP, SRC_SMCLK, DIV_1, 1'b0, 1'b1));
    measure_toggle(4 * (n_per + 1), cycles);           // Align to a change
    if (cycles < 0)
      note_failure("ta_out[1] never toggled");
    else
      for (int r = 0; r < 2; r++)
      begin
        measure_toggle(4 * (n_per + 1), cycles);
        check_eq("toggle interval", n_per + 1, cycles);
      end
    seen = irq_ta0;
    for (int i = 0; i < 2 * (n_per + 1) && !seen; i++)
    begin
      @(posedge mclk);
      #1;
      seen = irq_ta0;
    end
    if (!seen)
      note_failure("irq_ta0 never rose");
    else
    begin
      irq_ta0_acc = 1'b1;
      @(posedge mclk);
      #1;
      irq_ta0_acc = 1'b0;
      check_eq("irq_ta0 after acknowledge", 0, irq_ta0);
    end
    end_test();
  endtask

  task automatic test_updown();
    int          n_per;
    logic        saw_up, saw_down, back;
    logic [15:0] rd, prev, ctl_rd;
    begin_test("updown_div4");
    n_per = pick(8, 16);
    bus_write(CCR_BASE, n_per);
    bus_write(CTL, make_ctl(MC_UPDOWN, SRC_SMCLK, DIV_4, 1'b0, 1'b1));
    prev     = '0;
    saw_up   = 1'b0;
    saw_down = 1'b0;
    back     = 1'b0;
    for (int i = 0; i < 600 && !back; i++)
    begin
      bus_read(TAR, rd);
      check_max("TAR in up/down mode", n_per, rd);
      if (rd > prev)
        saw_up = 1'b1;
      if (rd < prev && !saw_down)
      begin
        bus_read(CTL, ctl_rd);       // Past the top with the bottom still ahead
        check_eq("TAIFG before bottom", 0, ctl_rd[TAIFG_BIT]);
        saw_down = 1'b1;
      end
      if (saw_down && rd == 0)
        back = 1'b1;                 // Bottom reached after falling
      prev = rd;
    end
    check_eq("rising readbacks seen", 1, saw_up);
    check_eq("falling readbacks seen", 1, saw_down);
    if (!back)
      note_failure("TAR never returned to 0 in up/down mode");
    else
    begin
      bus_read(CTL, rd);
      check_eq("TAIFG after return to 0", 1, rd[TAIFG_BIT]);
    end
    end_test();
  endtask

  task automatic test_ext_clock();
    int          k;
    logic [15:0] ctl_word, rd;
    begin_test("taclk_freeze_clear");
    k        = pick(3, 6);
    ctl_word = make_ctl(MC_CONT, SRC_TACLK, DIV_1, 1'b0, 1'b1);
    bus_write(CTL, ctl_word);
    repeat (k) taclk_pulse();
    bus_read(TAR, rd);
    check_eq("TAR after taclk pulses", k, rd);
    dbg_freeze = 1'b1;
    repeat (2) taclk_pulse();
    bus_read(TAR, rd);
    check_eq("TAR while frozen", k, rd);
    bus_write(CTL, ctl_word);        // Clear bit set again
    bus_read(TAR, rd);
    check_eq("TAR after clear", 0, rd);
    dbg_freeze = 1'b0;
    end_test();
  endtask

  //------------------------------------------------
  // Main sequence
  //------------------------------------------------
  initial
  begin
    puc         = 1'b1;
    per_addr    = '0;
    per_din     = '0;
    per_en      = 1'b0;
    per_wen     = 2'b00;
    aclk_en     = 1'b0;
    smclk_en    = 1'b1;
    taclk       = 1'b0;
    inclk       = 1'b0;
    dbg_freeze  = 1'b0;
    irq_ta0_acc = 1'b0;

    test_register_access();
    test_up_mode();
    test_priority();
    test_toggle_ack();
    test_updown();
    test_ext_clock();

    $display("%0d tests run, %0d passed, %0d failed",
             tests_run, tests_run - tests_failed, tests_failed);
    if (tests_failed == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

/* src.f */
hdl/timer_regs_pkg.sv
hdl/timer_ctrl_pkg.sv
hdl/timer_reg_bank.sv
hdl/timer_clock_gen.sv
hdl/timer_counter.sv
hdl/timer_compare_unit.sv
hdl/timer_a.sv
verification/timer_a_tb.sv

/* Bender.yml */
package:
  name: timer_a

sources:
  # Packages first, then RTL bottom up
  - hdl/timer_regs_pkg.sv
  - hdl/timer_ctrl_pkg.sv
  - hdl/timer_reg_bank.sv
  - hdl/timer_clock_gen.sv
  - hdl/timer_counter.sv
  - hdl/timer_compare_unit.sv
  - hdl/timer_a.sv

  # Testbench
  - target: test
    files:
      - verification/timer_a_tb.sv
